// ==== dv/sha512_tb.sv ====
// ----------------------------
// Testbench for the SHA-512 / SHA-384 accelerator
// Expected digests are the FIPS 180-4 example values
// Messages are padded here, as the host would do it
// Status is polled, so core latency is not assumed
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module sha512_tb
  import sha512_pkg::*;
;

  localparam int      NUM_TV         = 3;
  localparam int      ACK_LIMIT      = 4;
  localparam int      POLL_LIMIT     = 200;
  localparam int      TIMEOUT_CYCLES = NUM_TV * 2000 + 5000;
  localparam word32_t SEED           = 32'h56c0_5097;

  logic     clk = 1'b0;
  logic     reset_n;
  logic     cyc;
  logic     stb;
  logic     we;
  wb_addr_t adr;
  word32_t  dat_w;
  logic [3:0] sel;
  logic     ack;
  word32_t  dat_r;
  logic     notif_intr;

  int error_count;

  // Test vector table
  string        tv_msg    [0:NUM_TV-1];
  hash_mode_e   tv_mode   [0:NUM_TV-1];
  logic [511:0] tv_digest [0:NUM_TV-1];

  // Padded message, up to two blocks
  word32_t pad_words [0:63];
  int      pad_blocks;

  sha512_top dut0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .dat_w      (dat_w),
    .sel        (sel),
    .ack        (ack),
    .dat_r      (dat_r),
    .notif_intr (notif_intr)
  );

  always #10 clk = ~clk;

  // ------------------------------
  // Bus access
  // ------------------------------
  // One Wishbone classic transfer, launched and sampled on falling edges
  task automatic transfer(input logic write, input wb_addr_t addr, input word32_t wdata,
                          output word32_t rdata);
    int waited;
    waited = 0;
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = addr;
    dat_w = wdata;
    do begin
      @(negedge clk);
      waited++;
    end while (!ack && waited < ACK_LIMIT);
    if (!ack) begin
      $display("No ack from address %03h within %0d cycles", addr, ACK_LIMIT);
      error_count++;
    end
    rdata = dat_r;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
  endtask

  task automatic write_reg(input wb_addr_t addr, input word32_t data);
    word32_t unused;
    transfer(1'b1, addr, data, unused);
  endtask

  task automatic read_reg(input wb_addr_t addr, output word32_t data);
    transfer(1'b0, addr, '0, data);
  endtask

  task automatic expect_word(input string name, input word32_t got, input word32_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %08h expected %08h", name, got, exp);
      error_count++;
    end
  endtask

  // ------------------------------
  // Message handling
  // ------------------------------
  // FIPS padding: 0x80, zero fill, 128-bit bit length at the end
  task automatic pad_message(input string msg);
    logic [7:0]  msg_bytes [0:255];
    int          len;
    int          total;
    logic [31:0] bitlen;
    len        = msg.len();
    pad_blocks = (len + 17 + 127) / 128;
    total      = pad_blocks * 128;
    bitlen     = len * 8;
    for (int i = 0; i < 256; i++) begin
      msg_bytes[i] = 8'h00;
    end
    for (int i = 0; i < len; i++) begin
      msg_bytes[i] = msg[i];
    end
    msg_bytes[len]       = 8'h80;
    msg_bytes[total - 4] = bitlen[31:24];
    msg_bytes[total - 3] = bitlen[23:16];
    msg_bytes[total - 2] = bitlen[15:8];
    msg_bytes[total - 1] = bitlen[7:0];
    // Big-endian packing into bus words
    for (int i = 0; i < 64; i++) begin
      pad_words[i] = {msg_bytes[4*i], msg_bytes[4*i+1], msg_bytes[4*i+2], msg_bytes[4*i+3]};
    end
  endtask

  task automatic load_block(input int blk);
    for (int i = 0; i < 32; i++) begin
      write_reg(wb_addr_t'(ADDR_BLOCK + 4 * i), pad_words[32 * blk + i]);
    end
  endtask

  task automatic wait_valid();
    word32_t status;
    int      polls;
    status = '0;
    polls  = 0;
    while (status[1] !== 1'b1 && polls < POLL_LIMIT) begin
      read_reg(ADDR_STATUS, status);
      polls++;
    end
    if (status[1] !== 1'b1) begin
      $display("Digest never became valid after %0d status reads", POLL_LIMIT);
      error_count++;
    end
  endtask

  task automatic check_digest(input int idx);
    word32_t rdata;
    word32_t exp;
    for (int i = 0; i < 16; i++) begin
      read_reg(wb_addr_t'(ADDR_DIGEST + 4 * i), rdata);
      // Word 0 is the top 32 bits of the table value
      exp = word32_t'(tv_digest[idx] >> (32 * (15 - i)));
      expect_word($sformatf("DIGEST[%0d] entry %0d", i, idx), rdata, exp);
    end
  endtask

  // Hash one table entry, init on the first block, next on the rest
  task automatic run_entry(input int idx);
    word32_t rdata;
    pad_message(tv_msg[idx]);
    for (int b = 0; b < pad_blocks; b++) begin
      load_block(b);
      write_reg(ADDR_CTRL, {29'd0, tv_mode[idx], (b == 0) ? 2'b01 : 2'b10});
      wait_valid();
    end
    read_reg(ADDR_CTRL, rdata);
    expect_word("CTRL", rdata, {29'd0, tv_mode[idx], 2'b00});
    check_digest(idx);
  endtask

  // ------------------------------
  // Test sequences
  // ------------------------------
  task automatic check_reset_state();
    word32_t rdata;
    read_reg(ADDR_STATUS, rdata);
    expect_word("STATUS after reset", rdata, 32'h1);
    read_reg(ADDR_INTR, rdata);
    expect_word("INTR after reset", rdata, 32'h0);
    for (int i = 0; i < 16; i++) begin
      read_reg(wb_addr_t'(ADDR_DIGEST + 4 * i), rdata);
      expect_word($sformatf("DIGEST[%0d] after reset", i), rdata, 32'h0);
    end
    expect_word("notif_intr after reset", {31'd0, notif_intr}, 32'h0);
  endtask

  task automatic check_block_regs();
    word32_t rand_words [0:31];
    word32_t rdata;
    for (int i = 0; i < 32; i++) begin
      rand_words[i] = $urandom;
      write_reg(wb_addr_t'(ADDR_BLOCK + 4 * i), rand_words[i]);
    end
    for (int i = 0; i < 32; i++) begin
      read_reg(wb_addr_t'(ADDR_BLOCK + 4 * i), rdata);
      expect_word($sformatf("BLOCK[%0d]", i), rdata, rand_words[i]);
    end
    // Hole between INTR and BLOCK
    read_reg(9'h040, rdata);
    expect_word("unmapped 0x040", rdata, 32'h0);
  endtask

  // Block sampled at acceptance, so later writes must not disturb the hash
  task automatic check_busy_commands();
    word32_t rdata;
    pad_message(tv_msg[0]);
    load_block(0);
    write_reg(ADDR_CTRL, {29'd0, tv_mode[0], 2'b01});
    write_reg(ADDR_CTRL, {29'd0, tv_mode[0], 2'b10});
    write_reg(ADDR_BLOCK, $urandom);
    write_reg(wb_addr_t'(ADDR_BLOCK + 9'h07C), $urandom);
    read_reg(ADDR_STATUS, rdata);
    expect_word("STATUS while busy", rdata, 32'h0);
    wait_valid();
    // Dropped next must not have started another hash
    read_reg(ADDR_STATUS, rdata);
    expect_word("STATUS after busy run", rdata, 32'h3);
    check_digest(0);
  endtask

  task automatic check_interrupt();
    word32_t rdata;
    // Enable, and clear done left over from earlier hashes
    write_reg(ADDR_INTR, 32'h3);
    expect_word("notif_intr before hash", {31'd0, notif_intr}, 32'h0);
    run_entry(1);
    expect_word("notif_intr after hash", {31'd0, notif_intr}, 32'h1);
    read_reg(ADDR_INTR, rdata);
    expect_word("INTR after hash", rdata, 32'h3);
    write_reg(ADDR_INTR, 32'h3);
    expect_word("notif_intr after clear", {31'd0, notif_intr}, 32'h0);
    read_reg(ADDR_INTR, rdata);
    expect_word("INTR after clear", rdata, 32'h2);
    // Disabled: status sets, line stays low
    write_reg(ADDR_INTR, 32'h1);
    run_entry(0);
    read_reg(ADDR_INTR, rdata);
    expect_word("INTR disabled", rdata, 32'h1);
    expect_word("notif_intr disabled", {31'd0, notif_intr}, 32'h0);
  endtask

  task automatic load_table();
    tv_msg[0]    = "abc";
    tv_mode[0]   = MODE_512;
    tv_digest[0] = {64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2,
                    64'h0a9eeee64b55d39a, 64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd,
                    64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f};
    tv_msg[1]    = "abc";
    tv_mode[1]   = MODE_384;
    tv_digest[1] = {64'hcb00753f45a35e8b, 64'hb5a03d699ac65007, 64'h272c32ab0eded163,
                    64'h1a8b605a43ff5bed, 64'h8086072ba1e7cc23, 64'h58baeca134c825a7,
                    128'h0};
    // 896-bit message, two blocks once padded
    tv_msg[2]    = {"abcdefghbcdefghicdefghijdefghijkefghijklfghijklmghijklmn",
                    "hijklmnoijklmnopjklmnopqklmnopqrlmnopqrsmnopqrstnopqrstu"};
    tv_mode[2]   = MODE_512;
    tv_digest[2] = {64'h8e959b75dae313da, 64'h8cf4f72814fc143f, 64'h8f7779c6eb9f7fa1,
                    64'h7299aeadb6889018, 64'h501d289e4900f7e4, 64'h331b99dec4b5433a,
                    64'hc7d329eeb6dd2654, 64'h5e96e55b874be909};
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    reset_n     = 1'b0;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    dat_w       = '0;
    sel         = 4'hF;
    error_count = 0;
    void'($urandom(SEED));
    load_table();
    repeat (5) @(negedge clk);
    reset_n = 1'b1;

    check_reset_state();
    check_block_regs();
    for (int n = 0; n < NUM_TV; n++) begin
      run_entry(n);
    end
    check_busy_commands();
    check_interrupt();

    $display("Run complete, %0d errors", error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run did not finish", TIMEOUT_CYCLES);
    $display("Run aborted, %0d errors before timeout", error_count);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== include/sha512_k.svh ====
// ----------------------------
// SHA-512 round constants K0 to K79
// Needs word64_t in scope where included
// ----------------------------
`ifndef SHA512_K_SVH
`define SHA512_K_SVH

// Index 0 is the leftmost entry
localparam word64_t [0:79] sha512_k_table = {
  64'h428a2f98d728ae22,
  64'h7137449123ef65cd,
  64'hb5c0fbcfec4d3b2f,
  64'he9b5dba58189dbbc,
  64'h3956c25bf348b538,
  64'h59f111f1b605d019,
  64'h923f82a4af194f9b,
  64'hab1c5ed5da6d8118,
  64'hd807aa98a3030242,
  64'h12835b0145706fbe,
  64'h243185be4ee4b28c,
  64'h550c7dc3d5ffb4e2,
  64'h72be5d74f27b896f,
  64'h80deb1fe3b1696b1,
  64'h9bdc06a725c71235,
  64'hc19bf174cf692694,
  64'he49b69c19ef14ad2,
  64'hefbe4786384f25e3,
  64'h0fc19dc68b8cd5b5,
  64'h240ca1cc77ac9c65,
  64'h2de92c6f592b0275,
  64'h4a7484aa6ea6e483,
  64'h5cb0a9dcbd41fbd4,
  64'h76f988da831153b5,
  64'h983e5152ee66dfab,
  64'ha831c66d2db43210,
  64'hb00327c898fb213f,
  64'hbf597fc7beef0ee4,
  64'hc6e00bf33da88fc2,
  64'hd5a79147930aa725,
  64'h06ca6351e003826f,
  64'h142929670a0e6e70,
  64'h27b70a8546d22ffc,
  64'h2e1b21385c26c926,
  64'h4d2c6dfc5ac42aed,
  64'h53380d139d95b3df,
  64'h650a73548baf63de,
  64'h766a0abb3c77b2a8,
  64'h81c2c92e47edaee6,
  64'h92722c851482353b,
  64'ha2bfe8a14cf10364,
  64'ha81a664bbc423001,
  64'hc24b8b70d0f89791,
  64'hc76c51a30654be30,
  64'hd192e819d6ef5218,
  64'hd69906245565a910,
  64'hf40e35855771202a,
  64'h106aa07032bbd1b8,
  64'h19a4c116b8d2d0c8,
  64'h1e376c085141ab53,
  64'h2748774cdf8eeb99,
  64'h34b0bcb5e19b48a8,
  64'h391c0cb3c5c95a63,
  64'h4ed8aa4ae3418acb,
  64'h5b9cca4f7763e373,
  64'h682e6ff3d6b2b8a3,
  64'h748f82ee5defb2fc,
  64'h78a5636f43172f60,
  64'h84c87814a1f0ab72,
  64'h8cc702081a6439ec,
  64'h90befffa23631e28,
  64'ha4506cebde82bde9,
  64'hbef9a3f7b2c67915,
  64'hc67178f2e372532b,
  64'hca273eceea26619c,
  64'hd186b8c721c0c207,
  64'heada7dd6cde0eb1e,
  64'hf57d4f7fee6ed178,
  64'h06f067aa72176fba,
  64'h0a637dc5a2c898a6,
  64'h113f9804bef90dae,
  64'h1b710b35131c471b,
  64'h28db77f523047d84,
  64'h32caab7b40c72493,
  64'h3c9ebe0a15c9bebc,
  64'h431d67c49c100d4c,
  64'h4cc5d4becb3e42b6,
  64'h597f299cfc657e2a,
  64'h5fcb6fab3ad6faec,
  64'h6c44198c4a475817
};

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SHA-512 accelerator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f vlog.f --top-module sha512_tb -o sha512_sim
./obj_dir/sha512_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== src/sha512_core.sv ====
// ----------------------------
// SHA-512 / SHA-384 round engine, one round per cycle
// 80 rounds plus one finalization cycle per block
// Commands are dropped while ready is low
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module sha512_core
  import sha512_pkg::*;
(
  input  wire                 clk,
  input  wire                 reset_n,
  input  wire                 init_cmd,
  input  wire                 next_cmd,
  input  wire hash_mode_e     mode,
  input  wire word32_t [0:31] block,
  output logic                ready,
  output logic                digest_valid,
  output word32_t [0:15]      digest
);

  `include "sha512_k.svh"

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_ROUND,
    CORE_FINAL
  } core_state_e;

  core_state_e    state_q;
  round_t         round_q;
  hash_mode_e     mode_q;
  logic           valid_q;
  word64_t [0:7]  chain_q;
  word64_t [0:7]  h0_sel;

  // Working variables
  word64_t a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q;
  word64_t [0:7] wv;

  logic    accept;
  word64_t w;
  word64_t t1, t2;

  function automatic word64_t big_sigma0(input word64_t x);
    return rotr64(x, 28) ^ rotr64(x, 34) ^ rotr64(x, 39);
  endfunction

  function automatic word64_t big_sigma1(input word64_t x);
    return rotr64(x, 14) ^ rotr64(x, 18) ^ rotr64(x, 41);
  endfunction

  assign accept = (state_q == CORE_IDLE) && (init_cmd || next_cmd);
  assign h0_sel = (mode == MODE_512) ? H0_512 : H0_384;
  assign wv     = {a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q};

  // Block goes into the window in the acceptance cycle
  sha512_w_sched wsched0 (
    .clk     (clk),
    .reset_n (reset_n),
    .load    (accept),
    .block   (block),
    .advance (state_q == CORE_ROUND),
    .round   (round_q),
    .w       (w)
  );

  // ------------------------------
  // Compression step
  // ------------------------------
  assign t1 = h_q + big_sigma1(e_q) + ((e_q & f_q) ^ (~e_q & g_q))
            + sha512_k_table[round_q] + w;
  assign t2 = big_sigma0(a_q) + ((a_q & b_q) ^ (a_q & c_q) ^ (b_q & c_q));

  // Init starts from H0, next resumes from the chain
  always_ff @(posedge clk) begin
    if (accept) begin
      {a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q} <= init_cmd ? h0_sel : chain_q;
    end else if (state_q == CORE_ROUND) begin
      a_q <= t1 + t2;
      b_q <= a_q;
      c_q <= b_q;
      d_q <= c_q;
      e_q <= d_q + t1;
      f_q <= e_q;
      g_q <= f_q;
      h_q <= g_q;
    end
  end

  // ------------------------------
  // Control FSM and chaining state
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= CORE_IDLE;
      round_q <= '0;
      mode_q  <= MODE_384;
      valid_q <= 1'b0;
      chain_q <= '0;
    end else begin
      case (state_q)
        CORE_IDLE: begin
          if (accept) begin
            state_q <= CORE_ROUND;
            round_q <= '0;
            mode_q  <= mode;
            valid_q <= 1'b0;
            // init wins if both commands arrive together
            if (init_cmd) begin
              chain_q <= h0_sel;
            end
          end
        end
        CORE_ROUND: begin
          round_q <= round_q + 7'd1;
          if (round_q == 7'd79) begin
            state_q <= CORE_FINAL;
          end
        end
        CORE_FINAL: begin
          for (int i = 0; i < 8; i++) begin
            chain_q[i] <= chain_q[i] + wv[i];
          end
          valid_q <= 1'b1;
          state_q <= CORE_IDLE;
        end
        default: begin
          state_q <= CORE_IDLE;
        end
      endcase
    end
  end

  assign ready        = (state_q == CORE_IDLE);
  assign digest_valid = valid_q;

  // Digest words, big-endian halves of the chain
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      digest[2*i]   = chain_q[i][63:32];
      digest[2*i+1] = chain_q[i][31:0];
    end
    // SHA-384 keeps only H0..H5
    if (mode_q == MODE_384) begin
      digest[12:15] = '0;
    end
  end

endmodule

`default_nettype wire

// ==== src/sha512_pkg.sv ====
// ----------------------------
// Shared types and constants of the SHA-512 accelerator
// Register offsets are byte addresses on the 32-bit bus
// ----------------------------
`default_nettype none

package sha512_pkg;

  typedef logic [63:0] word64_t;
  typedef logic [31:0] word32_t;
  typedef logic [8:0]  wb_addr_t;
  typedef logic [6:0]  round_t;

  typedef enum logic {
    MODE_384 = 1'b0,
    MODE_512 = 1'b1
  } hash_mode_e;

  // Register map
  localparam wb_addr_t ADDR_CTRL   = 9'h010;
  localparam wb_addr_t ADDR_STATUS = 9'h018;
  localparam wb_addr_t ADDR_INTR   = 9'h01C;
  localparam wb_addr_t ADDR_BLOCK  = 9'h080;
  localparam wb_addr_t ADDR_DIGEST = 9'h100;

  // Initial hash values, H0 first
  localparam word64_t [0:7] H0_512 = {
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };
  localparam word64_t [0:7] H0_384 = {
    64'hcbbb9d5dc1059ed8, 64'h629a292a367cd507, 64'h9159015a3070dd17, 64'h152fecd8f70e5939,
    64'h67332667ffc00b31, 64'h8eb44a8768581511, 64'hdb0c2e0d64f98fa7, 64'h47b5481dbefa4fa4
  };

  // Rotate right, n in 1 to 63
  function automatic word64_t rotr64(input word64_t x, input int unsigned n);
    return (x >> n) | (x << (64 - n));
  endfunction

endpackage

`default_nettype wire

// ==== src/sha512_regs.sv ====
// ----------------------------
// Wishbone classic slave, 32-bit, single transfers
// Always acks one cycle after the request, no err
// Unmapped addresses read zero and ignore writes
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module sha512_regs
  import sha512_pkg::*;
(
  input  wire                 clk,
  input  wire                 reset_n,
  input  wire                 cyc,
  input  wire                 stb,
  input  wire                 we,
  input  wire wb_addr_t       adr,
  input  wire word32_t        dat_w,
  output logic                ack,
  output word32_t             dat_r,
  output logic                notif_intr,
  output logic                init_cmd,
  output logic                next_cmd,
  output hash_mode_e          mode,
  output word32_t [0:31]      block,
  input  wire                 ready,
  input  wire                 digest_valid,
  input  wire word32_t [0:15] digest
);

  logic           req;
  logic           wr_en;
  logic           enable_q;
  logic           done_q;
  logic           valid_d_q;
  word32_t        rd_data;

  // New request only if this cycle has not been acked yet
  assign req   = cyc && stb && !ack;
  assign wr_en = req && we;

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    rd_data = '0;
    if (adr[8:7] == ADDR_BLOCK[8:7]) begin
      rd_data = block[adr[6:2]];
    end else if (adr[8:6] == ADDR_DIGEST[8:6]) begin
      rd_data = digest[adr[5:2]];
    end else if (adr[8:2] == ADDR_CTRL[8:2]) begin
      // init and next read back as zero
      rd_data = {29'd0, mode, 2'b00};
    end else if (adr[8:2] == ADDR_STATUS[8:2]) begin
      rd_data = {30'd0, digest_valid, ready};
    end else if (adr[8:2] == ADDR_INTR[8:2]) begin
      rd_data = {30'd0, enable_q, done_q};
    end
  end

  // ------------------------------
  // Bus handshake and registers
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack       <= 1'b0;
      dat_r     <= '0;
      init_cmd  <= 1'b0;
      next_cmd  <= 1'b0;
      mode      <= MODE_384;
      block     <= '0;
      enable_q  <= 1'b0;
      done_q    <= 1'b0;
      valid_d_q <= 1'b0;
    end else begin
      ack       <= req;
      init_cmd  <= 1'b0;
      next_cmd  <= 1'b0;
      valid_d_q <= digest_valid;
      if (req) begin
        dat_r <= rd_data;
      end

      // Writes land on the edge where ack rises
      if (wr_en) begin
        if (adr[8:7] == ADDR_BLOCK[8:7]) begin
          block[adr[6:2]] <= dat_w;
        end else if (adr[8:2] == ADDR_CTRL[8:2]) begin
          init_cmd <= dat_w[0];
          next_cmd <= dat_w[1];
          mode     <= hash_mode_e'(dat_w[2]);
        end else if (adr[8:2] == ADDR_INTR[8:2]) begin
          enable_q <= dat_w[1];
          if (dat_w[0]) begin
            done_q <= 1'b0;
          end
        end
      end

      // Completion beats a same-cycle clear
      if (digest_valid && !valid_d_q) begin
        done_q <= 1'b1;
      end
    end
  end

  assign notif_intr = done_q && enable_q;

endmodule

`default_nettype wire

// ==== src/sha512_top.sv ====
// ----------------------------
// SHA-512 / SHA-384 accelerator top level
// Byte enables are ignored, writes are full words
// Host pads the message
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module sha512_top
  import sha512_pkg::*;
(
  input  wire           clk,
  input  wire           reset_n,
  input  wire           cyc,
  input  wire           stb,
  input  wire           we,
  input  wire wb_addr_t adr,
  input  wire word32_t  dat_w,
  input  wire [3:0]     sel,
  output logic          ack,
  output word32_t       dat_r,
  output logic          notif_intr
);

  // Register block to core
  logic           init_cmd;
  logic           next_cmd;
  hash_mode_e     mode;
  word32_t [0:31] block;

  // Core to register block
  logic           ready;
  logic           digest_valid;
  word32_t [0:15] digest;

  sha512_regs regs0 (
    .clk          (clk),
    .reset_n      (reset_n),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .dat_w        (dat_w),
    .ack          (ack),
    .dat_r        (dat_r),
    .notif_intr   (notif_intr),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .mode         (mode),
    .block        (block),
    .ready        (ready),
    .digest_valid (digest_valid),
    .digest       (digest)
  );

  sha512_core core0 (
    .clk          (clk),
    .reset_n      (reset_n),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .mode         (mode),
    .block        (block),
    .ready        (ready),
    .digest_valid (digest_valid),
    .digest       (digest)
  );

endmodule

`default_nettype wire

// ==== src/sha512_w_sched.sv ====
// ----------------------------
// SHA-512 message schedule, one word per round
// load has priority over advance
// w is combinational from the window and round
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module sha512_w_sched
  import sha512_pkg::*;
(
  input  wire                 clk,
  input  wire                 reset_n,
  input  wire                 load,
  input  wire word32_t [0:31] block,
  input  wire                 advance,
  input  wire round_t         round,
  output word64_t             w
);

  // Window holds W[t-16] .. W[t-1] once t reaches 16
  word64_t [0:15] win_q;
  word64_t        w_new;

  function automatic word64_t small_sigma0(input word64_t x);
    return rotr64(x, 1) ^ rotr64(x, 8) ^ (x >> 7);
  endfunction

  function automatic word64_t small_sigma1(input word64_t x);
    return rotr64(x, 19) ^ rotr64(x, 61) ^ (x >> 6);
  endfunction

  // ------------------------------
  // Next schedule word
  // ------------------------------
  assign w_new = small_sigma1(win_q[14]) + win_q[9] + small_sigma0(win_q[1]) + win_q[0];

  // First 16 rounds read the block words in place
  assign w = (round < 7'd16) ? win_q[round[3:0]] : w_new;

  // ------------------------------
  // Window update
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      win_q <= '0;
    end else if (load) begin
      // Two bus words per schedule word, big-endian
      for (int i = 0; i < 16; i++) begin
        win_q[i] <= {block[2*i], block[2*i+1]};
      end
    end else if (advance && (round >= 7'd16)) begin
      // Drop the oldest word, append the new one
      win_q <= {win_q[1:15], w_new};
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
src/sha512_pkg.sv
src/sha512_w_sched.sv
src/sha512_core.sv
src/sha512_regs.sv
src/sha512_top.sv
dv/sha512_tb.sv
